// File: src/tlb_pkg.sv
`default_nettype none

package tlb_pkg;

    // Sv32 address split
    localparam int VPN_W    = 20;
    localparam int PPN_W    = 22;
    localparam int OFFSET_W = 12;

    // command to the ways, one per cycle
    typedef enum logic [1:0] {
        NONE       = 2'd0,
        RESOLVE    = 2'd1,
        WRITE      = 2'd2,
        INVALIDATE = 2'd3
    } tlb_cmd_e;

    typedef enum logic [1:0] {
        LOAD  = 2'd0,
        STORE = 2'd1,
        FETCH = 2'd2
    } tlb_access_e;

    // same bit order as the low byte of a page table entry
    typedef struct packed {
        logic d;
        logic a;
        logic g;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } tlb_perm_t;

    typedef struct packed {
        logic [31:0] vaddr;
        tlb_access_e access;
        logic        user;
    } tlb_lookup_t;

    typedef struct packed {
        logic [VPN_W-1:0] vpn;
        logic [PPN_W-1:0] ppn;
        tlb_perm_t        perm;
    } tlb_fill_t;

    typedef struct packed {
        logic                      hit;
        logic                      fault;
        logic [PPN_W+OFFSET_W-1:0] paddr;
    } tlb_rsp_t;

endpackage

`default_nettype wire

// File: src/tlb_mem_1w1r.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_mem_1w1r #(
    parameter int ELEMENTS_W = 4,
    parameter int WIDTH      = 8
) (
    input  wire logic                  clk,
    input  wire logic                  read,
    input  wire logic [ELEMENTS_W-1:0] read_index,
    output logic      [WIDTH-1:0]      read_data,
    input  wire logic                  write,
    input  wire logic [ELEMENTS_W-1:0] write_index,
    input  wire logic [WIDTH-1:0]      write_data
);

    localparam int ELEMENTS = 2**ELEMENTS_W;

    logic [WIDTH-1:0] storage [ELEMENTS];

    always_ff @(posedge clk) begin
        if (write) begin
            storage[write_index] <= write_data;
        end
    end

    // read data holds until the next read
    always_ff @(posedge clk) begin
        if (read) begin
            read_data <= storage[read_index];
        end
    end

endmodule

`default_nettype wire

// File: src/tlb_way.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_way import tlb_pkg::*; #(
    parameter int ENTRIES_W = 4
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire tlb_cmd_e             cmd,
    input  wire logic [VPN_W-1:0]     rd_vpn,
    input  wire tlb_fill_t            wr_fill,
    input  wire logic [ENTRIES_W-1:0] inv_index,
    output logic                      hit,
    output logic      [PPN_W-1:0]     ppn,
    output tlb_perm_t                 perm
);

    localparam int VTAG_W = VPN_W - ENTRIES_W;

    // vpn = {vtag, set index}
    logic [ENTRIES_W-1:0] rd_index;
    logic [VTAG_W-1:0]    rd_vtag;
    logic [ENTRIES_W-1:0] wr_index;
    logic [VTAG_W-1:0]    wr_vtag;

    logic                 do_read;
    logic                 do_write;
    logic                 perm_write;
    logic [ENTRIES_W-1:0] perm_wr_index;
    tlb_perm_t            perm_wr_data;

    logic [VTAG_W-1:0]    vtag_rd;
    logic [VTAG_W-1:0]    held_vtag;
    logic                 read_done;

    assign rd_index = rd_vpn[ENTRIES_W-1:0];
    assign rd_vtag  = rd_vpn[VPN_W-1:ENTRIES_W];
    assign wr_index = wr_fill.vpn[ENTRIES_W-1:0];
    assign wr_vtag  = wr_fill.vpn[VPN_W-1:ENTRIES_W];

    assign do_read    = (cmd == RESOLVE);
    assign do_write   = (cmd == WRITE);
    assign perm_write = do_write || (cmd == INVALIDATE);

    // invalidate clears the whole access tag, v included
    assign perm_wr_index = (cmd == INVALIDATE) ? inv_index : wr_index;
    assign perm_wr_data  = (cmd == INVALIDATE) ? '0 : wr_fill.perm;

    tlb_mem_1w1r #(.ELEMENTS_W(ENTRIES_W), .WIDTH(PPN_W)) i_ppn_mem (
        .clk         (clk),
        .read        (do_read),
        .read_index  (rd_index),
        .read_data   (ppn),
        .write       (do_write),
        .write_index (wr_index),
        .write_data  (wr_fill.ppn)
    );

    tlb_mem_1w1r #(.ELEMENTS_W(ENTRIES_W), .WIDTH(VTAG_W)) i_vtag_mem (
        .clk         (clk),
        .read        (do_read),
        .read_index  (rd_index),
        .read_data   (vtag_rd),
        .write       (do_write),
        .write_index (wr_index),
        .write_data  (wr_vtag)
    );

    tlb_mem_1w1r #(.ELEMENTS_W(ENTRIES_W), .WIDTH(8)) i_perm_mem (
        .clk         (clk),
        .read        (do_read),
        .read_index  (rd_index),
        .read_data   (perm),
        .write       (perm_write),
        .write_index (perm_wr_index),
        .write_data  (perm_wr_data)
    );

    // tag of the address being resolved, compared one cycle later
    always_ff @(posedge clk) begin
        if (do_read) begin
            held_vtag <= rd_vtag;
        end
    end

    // no hit before the first read after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_done <= 1'b0;
        end else if (do_read) begin
            read_done <= 1'b1;
        end
    end

    assign hit = read_done && perm.v && (vtag_rd == held_vtag);

endmodule

`default_nettype wire

// File: src/tlb_set_array.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_set_array import tlb_pkg::*; #(
    parameter int ENTRIES_W = 4,
    parameter int WAYS_W    = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire tlb_cmd_e             cmd,
    input  wire logic [VPN_W-1:0]     rd_vpn,
    input  wire tlb_fill_t            wr_fill,
    input  wire logic [ENTRIES_W-1:0] inv_index,
    output logic                      hit,
    output logic      [PPN_W-1:0]     ppn,
    output tlb_perm_t                 perm
);

    localparam int WAYS = 2**WAYS_W;

    logic [WAYS_W-1:0] victim_ptr;

    tlb_cmd_e          way_cmd  [WAYS];
    logic [WAYS-1:0]   way_hit;
    logic [PPN_W-1:0]  way_ppn  [WAYS];
    tlb_perm_t         way_perm [WAYS];

    // round-robin refill
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            victim_ptr <= '0;
        end else if (cmd == WRITE) begin
            victim_ptr <= victim_ptr + 1'b1;
        end
    end

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        // write only reaches the victim, the rest see every command
        assign way_cmd[w] = (cmd == WRITE && victim_ptr != WAYS_W'(w)) ? NONE : cmd;

        tlb_way #(.ENTRIES_W(ENTRIES_W)) i_way (
            .clk       (clk),
            .rst_n     (rst_n),
            .cmd       (way_cmd[w]),
            .rd_vpn    (rd_vpn),
            .wr_fill   (wr_fill),
            .inv_index (inv_index),
            .hit       (way_hit[w]),
            .ppn       (way_ppn[w]),
            .perm      (way_perm[w])
        );
    end

    // walk downward so the lowest hitting way wins
    always_comb begin
        hit  = 1'b0;
        ppn  = way_ppn[0];
        perm = way_perm[0];
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (way_hit[i]) begin
                hit  = 1'b1;
                ppn  = way_ppn[i];
                perm = way_perm[i];
            end
        end
    end

    // refill only follows a miss, so a page never lives in two ways
    a_single_way_hit : assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(way_hit)
    ) else $error("more than one way hit: %b", way_hit);

endmodule

`default_nettype wire

// File: src/tlb_cmd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_cmd_sequencer import tlb_pkg::*; #(
    parameter int ENTRIES_W = 4
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 lookup_valid,
    input  wire tlb_lookup_t          lookup,
    input  wire logic                 fill_valid,
    input  wire tlb_fill_t            fill,
    input  wire logic                 flush,
    output logic                      busy,
    output tlb_cmd_e                  cmd,
    output logic      [VPN_W-1:0]     rd_vpn,
    output tlb_fill_t                 wr_fill,
    output logic      [ENTRIES_W-1:0] inv_index,
    output logic                      resolve_issue
);

    logic [ENTRIES_W-1:0] flush_cnt;

    // reset starts the same walk a flush does
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b1;
            flush_cnt <= '0;
        end else if (busy) begin
            flush_cnt <= flush_cnt + 1'b1;
            if (flush_cnt == '1) begin
                busy <= 1'b0;
            end
        end else if (flush) begin
            busy      <= 1'b1;
            flush_cnt <= '0;
        end
    end

    always_comb begin
        if (busy) begin
            cmd = INVALIDATE;
        end else if (fill_valid) begin
            cmd = WRITE;
        end else if (lookup_valid) begin
            cmd = RESOLVE;
        end else begin
            cmd = NONE;
        end
    end

    assign resolve_issue = (cmd == RESOLVE);
    assign rd_vpn        = lookup.vaddr[31:OFFSET_W];
    assign wr_fill       = fill;
    assign inv_index     = flush_cnt;

    // requester rules
    a_one_strobe : assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0({lookup_valid, fill_valid, flush})
    ) else $error("more than one strobe in a cycle");

    a_idle_while_busy : assert property (
        @(posedge clk) disable iff (!rst_n) busy |-> !(lookup_valid || fill_valid || flush)
    ) else $error("strobe issued while the flush walk runs");

endmodule

`default_nettype wire

// File: src/tlb_resolve_out.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_resolve_out import tlb_pkg::*; (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             resolve_issue,
    input  wire tlb_lookup_t      lookup,
    input  wire logic             hit,
    input  wire logic [PPN_W-1:0] ppn,
    input  wire tlb_perm_t        perm,
    output logic                  rsp_valid,
    output tlb_rsp_t              rsp
);

    logic                pending;
    logic [OFFSET_W-1:0] offset_q;
    tlb_access_e         access_q;
    logic                user_q;
    logic                access_fault;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else begin
            pending <= resolve_issue;
        end
    end

    // request fields, lined up with the way read data
    always_ff @(posedge clk) begin
        if (resolve_issue) begin
            offset_q <= lookup.vaddr[OFFSET_W-1:0];
            access_q <= lookup.access;
            user_q   <= lookup.user;
        end
    end

    // store needs dirty set as well as w
    always_comb begin
        case (access_q)
            LOAD:    access_fault = !perm.r;
            STORE:   access_fault = !(perm.w && perm.d);
            FETCH:   access_fault = !perm.x;
            default: access_fault = 1'b1;
        endcase
    end

    assign rsp_valid = pending;
    assign rsp.hit   = hit;
    // no SUM, so supervisor on a user page faults too
    assign rsp.fault = hit && ((user_q != perm.u) || !perm.a || access_fault);
    assign rsp.paddr = {ppn, offset_q};

endmodule

`default_nettype wire

// File: src/tlb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_top import tlb_pkg::*; #(
    parameter int ENTRIES_W = 4,
    parameter int WAYS_W    = 2
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        lookup_valid,
    input  wire tlb_lookup_t lookup,
    input  wire logic        fill_valid,
    input  wire tlb_fill_t   fill,
    input  wire logic        flush,
    output logic             busy,
    output logic             rsp_valid,
    output tlb_rsp_t         rsp
);

    tlb_cmd_e             cmd;
    logic [VPN_W-1:0]     rd_vpn;
    tlb_fill_t            wr_fill;
    logic [ENTRIES_W-1:0] inv_index;
    logic                 resolve_issue;

    logic                 hit;
    logic [PPN_W-1:0]     ppn;
    tlb_perm_t            perm;

    tlb_cmd_sequencer #(.ENTRIES_W(ENTRIES_W)) i_cmd_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .lookup_valid  (lookup_valid),
        .lookup        (lookup),
        .fill_valid    (fill_valid),
        .fill          (fill),
        .flush         (flush),
        .busy          (busy),
        .cmd           (cmd),
        .rd_vpn        (rd_vpn),
        .wr_fill       (wr_fill),
        .inv_index     (inv_index),
        .resolve_issue (resolve_issue)
    );

    tlb_set_array #(.ENTRIES_W(ENTRIES_W), .WAYS_W(WAYS_W)) i_set_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .rd_vpn    (rd_vpn),
        .wr_fill   (wr_fill),
        .inv_index (inv_index),
        .hit       (hit),
        .ppn       (ppn),
        .perm      (perm)
    );

    tlb_resolve_out i_resolve_out (
        .clk           (clk),
        .rst_n         (rst_n),
        .resolve_issue (resolve_issue),
        .lookup        (lookup),
        .hit           (hit),
        .ppn           (ppn),
        .perm          (perm),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp)
    );

endmodule

`default_nettype wire

// File: verif/tlb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_tb import tlb_pkg::*; ();

    typedef enum logic [1:0] {
        K_FILL,
        K_LOOKUP,
        K_FLUSH
    } row_kind_e;

    // fill rows carry the vpn in vaddr[31:12] and lookup rows the expected ppn
    typedef struct packed {
        row_kind_e        kind;
        logic             burst;
        logic [31:0]      vaddr;
        tlb_access_e      access;
        logic             user;
        logic [PPN_W-1:0] ppn;
        tlb_perm_t        perm;
        logic             exp_hit;
        logic             exp_fault;
    } row_t;

    // access tags in d a g u x w r v order
    localparam tlb_perm_t P_USER_RWX       = 8'hDF;
    localparam tlb_perm_t P_SUP_RW         = 8'hC7;
    localparam tlb_perm_t P_SUP_RX         = 8'hCB;
    localparam tlb_perm_t P_USER_RW_CLEAN  = 8'h57;
    localparam tlb_perm_t P_USER_R_NOT_ACC = 8'h93;
    localparam tlb_perm_t P_USER_X         = 8'h59;

    logic        clk;
    logic        rst_n;
    logic        lookup_valid;
    tlb_lookup_t lookup;
    logic        fill_valid;
    tlb_fill_t   fill;
    logic        flush;
    logic        busy;
    logic        rsp_valid;
    tlb_rsp_t    rsp;

    row_t rows[$];
    int   error_count = 0;
    int   check_count = 0;
    int   cycle_count = 0;
    int   cycle_limit = 100000;

    tlb_top #(.ENTRIES_W(4), .WAYS_W(2)) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_valid (lookup_valid),
        .lookup       (lookup),
        .fill_valid   (fill_valid),
        .fill         (fill),
        .flush        (flush),
        .busy         (busy),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic fill_row(input logic [VPN_W-1:0] vpn, input logic [PPN_W-1:0] ppn,
                            input tlb_perm_t perm);
        rows.push_back(row_t'{K_FILL, 1'b0, {vpn, 12'h000}, LOAD, 1'b0, ppn, perm, 1'b0, 1'b0});
    endtask

    task automatic lookup_row(input logic [31:0] vaddr, input tlb_access_e access,
                              input logic user, input logic hit, input logic fault,
                              input logic [PPN_W-1:0] ppn, input logic burst);
        rows.push_back(row_t'{K_LOOKUP, burst, vaddr, access, user, ppn, 8'h00, hit, fault});
    endtask

    task automatic flush_row();
        rows.push_back(row_t'{K_FLUSH, 1'b0, 32'h0, LOAD, 1'b0, 22'h0, 8'h00, 1'b0, 1'b0});
    endtask

    task automatic build_table();
        // empty buffer after the reset walk
        lookup_row(32'h0001_2345, LOAD,  1'b0, 1'b0, 1'b0, 22'h0, 1'b0);
        lookup_row(32'hFFFF_F000, FETCH, 1'b1, 1'b0, 1'b0, 22'h0, 1'b0);
        // refill then hit and a miss on another tag in the same set
        fill_row(20'h12345, 22'h1ABCDE, P_USER_RWX);
        lookup_row(32'h1234_5678, LOAD, 1'b1, 1'b1, 1'b0, 22'h1ABCDE, 1'b0);
        lookup_row(32'h2234_5010, LOAD, 1'b1, 1'b0, 1'b0, 22'h0, 1'b0);
        // permission rules with one set per page
        fill_row(20'h00100, 22'h000100, P_SUP_RW);
        lookup_row(32'h0010_0004, LOAD,  1'b0, 1'b1, 1'b0, 22'h000100, 1'b0);
        lookup_row(32'h0010_0004, STORE, 1'b0, 1'b1, 1'b0, 22'h000100, 1'b0);
        lookup_row(32'h0010_0004, FETCH, 1'b0, 1'b1, 1'b1, 22'h000100, 1'b0);
        lookup_row(32'h0010_0004, LOAD,  1'b1, 1'b1, 1'b1, 22'h000100, 1'b0);
        fill_row(20'h00201, 22'h000201, P_SUP_RX);
        lookup_row(32'h0020_1100, LOAD,  1'b0, 1'b1, 1'b0, 22'h000201, 1'b0);
        lookup_row(32'h0020_1100, FETCH, 1'b0, 1'b1, 1'b0, 22'h000201, 1'b0);
        lookup_row(32'h0020_1100, STORE, 1'b0, 1'b1, 1'b1, 22'h000201, 1'b0);
        fill_row(20'h00302, 22'h000302, P_USER_RW_CLEAN);
        lookup_row(32'h0030_2200, STORE, 1'b1, 1'b1, 1'b1, 22'h000302, 1'b0);
        lookup_row(32'h0030_2200, LOAD,  1'b1, 1'b1, 1'b0, 22'h000302, 1'b0);
        lookup_row(32'h0030_2200, LOAD,  1'b0, 1'b1, 1'b1, 22'h000302, 1'b0);
        fill_row(20'h00403, 22'h000403, P_USER_R_NOT_ACC);
        lookup_row(32'h0040_3300, LOAD,  1'b1, 1'b1, 1'b1, 22'h000403, 1'b0);
        fill_row(20'h00504, 22'h000504, P_USER_X);
        lookup_row(32'h0050_4010, FETCH, 1'b1, 1'b1, 1'b0, 22'h000504, 1'b0);
        lookup_row(32'h0050_4010, LOAD,  1'b1, 1'b1, 1'b1, 22'h000504, 1'b0);
        // five pages into set 7 so the fifth evicts the first
        fill_row(20'h01007, 22'h011007, P_USER_RWX);
        fill_row(20'h02007, 22'h022007, P_USER_RWX);
        fill_row(20'h03007, 22'h033007, P_USER_RWX);
        fill_row(20'h04007, 22'h044007, P_USER_RWX);
        fill_row(20'h05007, 22'h055007, P_USER_RWX);
        lookup_row(32'h0100_7ABC, LOAD, 1'b1, 1'b0, 1'b0, 22'h0, 1'b0);
        lookup_row(32'h0200_7ABC, LOAD, 1'b1, 1'b1, 1'b0, 22'h022007, 1'b0);
        lookup_row(32'h0300_7ABC, LOAD, 1'b1, 1'b1, 1'b0, 22'h033007, 1'b0);
        lookup_row(32'h0400_7ABC, LOAD, 1'b1, 1'b1, 1'b0, 22'h044007, 1'b0);
        lookup_row(32'h0500_7ABC, LOAD, 1'b1, 1'b1, 1'b0, 22'h055007, 1'b0);
        // back to back lookups give one response per cycle
        lookup_row(32'h1234_5678, LOAD,  1'b1, 1'b1, 1'b0, 22'h1ABCDE, 1'b1);
        lookup_row(32'h0010_0004, STORE, 1'b0, 1'b1, 1'b0, 22'h000100, 1'b1);
        lookup_row(32'h0500_70FF, FETCH, 1'b1, 1'b1, 1'b0, 22'h055007, 1'b1);
        lookup_row(32'h0100_7ABC, LOAD,  1'b1, 1'b0, 1'b0, 22'h0, 1'b1);
        lookup_row(32'h0050_4010, FETCH, 1'b1, 1'b1, 1'b0, 22'h000504, 1'b0);
        // everything gone after a flush
        flush_row();
        lookup_row(32'h1234_5678, LOAD,  1'b1, 1'b0, 1'b0, 22'h0, 1'b0);
        lookup_row(32'h0010_0004, LOAD,  1'b0, 1'b0, 1'b0, 22'h0, 1'b0);
        lookup_row(32'h0500_70FF, FETCH, 1'b1, 1'b0, 1'b0, 22'h0, 1'b0);
        lookup_row(32'h0020_1100, LOAD,  1'b0, 1'b0, 1'b0, 22'h0, 1'b0);
    endtask

    // counts falling edges with busy high from the current one on
    task automatic count_busy(output int cycles);
        cycles = 0;
        while (busy && cycles < 64) begin
            if (rsp_valid) begin
                error_count++;
                $display("a response came out while the invalidate walk was running");
            end
            cycles++;
            @(negedge clk);
        end
        if (busy) begin
            error_count++;
            $display("busy stayed high for more than 64 cycles");
        end
    endtask

    task automatic apply_row(input int idx);
        row_t r;
        int   cycles;
        int   errors_before;
        r = rows[idx];
        errors_before = error_count;
        case (r.kind)
            K_FILL: begin
                fill.vpn   = r.vaddr[31:12];
                fill.ppn   = r.ppn;
                fill.perm  = r.perm;
                fill_valid = 1'b1;
            end
            K_LOOKUP: begin
                lookup.vaddr  = r.vaddr;
                lookup.access = r.access;
                lookup.user   = r.user;
                lookup_valid  = 1'b1;
            end
            default: begin
                flush = 1'b1;
            end
        endcase
        @(negedge clk);
        fill_valid   = 1'b0;
        lookup_valid = 1'b0;
        flush        = 1'b0;
        if (r.kind == K_LOOKUP) begin
            if (!rsp_valid) begin
                error_count++;
                $display("no response one cycle after the lookup of %08h", r.vaddr);
            end else begin
                check_value("rsp.hit", 64'(r.exp_hit), 64'(rsp.hit));
                check_value("rsp.fault", 64'(r.exp_fault), 64'(rsp.fault));
                if (r.exp_hit) begin
                    check_value("rsp.paddr", 64'({r.ppn, r.vaddr[11:0]}), 64'(rsp.paddr));
                end
            end
        end else if (r.kind == K_FLUSH) begin
            count_busy(cycles);
            check_value("busy cycles after flush", 64'(16), 64'(cycles));
        end
        // the response lasts a single cycle
        if (!r.burst) begin
            @(negedge clk);
            check_value("rsp_valid", 64'(0), 64'(rsp_valid));
        end
        $display("row %0d %s %08h: %s", idx, r.kind.name(), r.vaddr,
                 (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    initial begin
        int cycles;
        rst_n        = 1'b0;
        lookup_valid = 1'b0;
        lookup       = '0;
        fill_valid   = 1'b0;
        fill         = '0;
        flush        = 1'b0;
        build_table();
        cycle_limit = rows.size() * 20 + 200;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        count_busy(cycles);
        check_value("busy cycles after reset", 64'(16), 64'(cycles));
        $display("reset walk: busy for %0d cycles", cycles);
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(i);
        end
        $display("%0d rows, %0d checks, %0d errors", rows.size(), check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        while (cycle_count <= cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("the run did not finish within %0d cycles", cycle_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
src/tlb_pkg.sv
src/tlb_mem_1w1r.sv
src/tlb_way.sv
src/tlb_set_array.sv
src/tlb_cmd_sequencer.sv
src/tlb_resolve_out.sv
src/tlb_top.sv
verif/tlb_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tlb_tb -o tlb_sim
output=$(./obj_dir/tlb_sim)
echo "$output"

if grep -qF "TEST RESULT: PASS" <<< "$output"; then
    exit 0
fi
exit 1
